// File: verilog/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        b_reg,
        b_four,     // link address
        b_imm
    } b_src_e;

    typedef enum logic [3:0] {
        br_none,
        br_jal,
        br_jalr,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        a_pc;      // pc as operand a
        b_src_e      b_src;
        br_e         branch;
        logic [31:0] imm;       // raw, sign in bit 31
        logic [4:0]  rd;
        logic        reg_wr;
        logic        illegal;
    } ex_ctrl_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       reg_wr;
        logic       illegal;
        logic       is_jmp_raw; // taken, not yet gated by valid
    } ex_res_t;

endpackage

`default_nettype wire

// File: verilog/ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ex_decode import ex_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire logic [31:0] instr,
    output ex_ctrl_t         ctrl
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        shamt_ok;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // shamt bit 5 only exists on a 64-bit datapath
    assign shamt_ok = (XLEN == 64) || !instr[25];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.b_src  = b_reg;
        ctrl.branch = br_none;
        ctrl.rd     = instr[11:7];
        case (instr[6:0])
            op_imm: begin
                ctrl.b_src  = b_imm;
                ctrl.imm    = imm_i;
                ctrl.reg_wr = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b111: ctrl.alu_op = alu_and;
                    3'b001: begin
                        ctrl.alu_op  = alu_sll;
                        ctrl.illegal = !(shamt_ok && instr[31:26] == 6'b000000);
                    end
                    default: begin // 101
                        ctrl.alu_op  = instr[30] ? alu_sra : alu_srl;
                        ctrl.illegal = !(shamt_ok && instr[31] == 1'b0 && instr[29:26] == 4'b0);
                    end
                endcase
            end
            op_reg: begin
                ctrl.reg_wr = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000000, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'b0000000, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'b0000000, 3'b011}: ctrl.alu_op = alu_sltu;
                    {7'b0000000, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'b0000000, 3'b101}: ctrl.alu_op = alu_srl;
                    {7'b0100000, 3'b101}: ctrl.alu_op = alu_sra;
                    {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    default:              ctrl.illegal = 1'b1;
                endcase
            end
            op_lui: begin
                ctrl.alu_op = alu_pass_b;
                ctrl.b_src  = b_imm;
                ctrl.imm    = imm_u;
                ctrl.reg_wr = 1'b1;
            end
            op_auipc: begin
                ctrl.a_pc   = 1'b1;
                ctrl.b_src  = b_imm;
                ctrl.imm    = imm_u;
                ctrl.reg_wr = 1'b1;
            end
            op_jal: begin
                ctrl.a_pc   = 1'b1;
                ctrl.b_src  = b_four;   // rd gets pc + 4
                ctrl.branch = br_jal;
                ctrl.imm    = imm_j;
                ctrl.reg_wr = 1'b1;
            end
            op_jalr: begin
                ctrl.a_pc    = 1'b1;
                ctrl.b_src   = b_four;
                ctrl.branch  = br_jalr;
                ctrl.imm     = imm_i;
                ctrl.reg_wr  = 1'b1;
                ctrl.illegal = funct3 != 3'b000;
            end
            op_branch: begin
                ctrl.alu_op = alu_sub;  // flags compare src1 with src2
                ctrl.imm    = imm_b;
                case (funct3)
                    3'b000:  ctrl.branch = br_eq;
                    3'b001:  ctrl.branch = br_ne;
                    3'b100:  ctrl.branch = br_lt;
                    3'b101:  ctrl.branch = br_ge;
                    3'b110:  ctrl.branch = br_ltu;
                    3'b111:  ctrl.branch = br_geu;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.reg_wr = 1'b0;
            ctrl.branch = br_none;  // never redirect on a bad instruction
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; #(
    parameter int XLEN = 64
) (
    input  alu_op_e              op,
    input  wire logic [XLEN-1:0] a,
    input  wire logic [XLEN-1:0] b,
    output logic      [XLEN-1:0] result,
    output logic                 zero,
    output logic                 lt,
    output logic                 ltu
);

    localparam int SH_W = $clog2(XLEN);

    logic [SH_W-1:0] shamt;

    assign shamt = b[SH_W-1:0];

    // compare flags shared with the branch unit
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = XLEN'(lt);
            alu_sltu:   result = XLEN'(ltu);
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    assign zero = result == '0;   // a == b under alu_sub

endmodule

`default_nettype wire

// File: verilog/ex_branch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch import ex_pkg::*; #(
    parameter int XLEN = 64
) (
    input  br_e                  branch,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [XLEN-1:0] src1,
    input  wire logic [XLEN-1:0] imm,
    input  wire logic            zero,
    input  wire logic            lt,
    input  wire logic            ltu,
    output logic      [XLEN-1:0] nxtpc,
    output logic                 taken
);

    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;

    always_comb begin
        case (branch)
            br_jal, br_jalr: taken = 1'b1;
            br_eq:           taken = zero;
            br_ne:           taken = !zero;
            br_lt:           taken = lt;
            br_ge:           taken = !lt;
            br_ltu:          taken = ltu;
            br_geu:          taken = !ltu;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum = src1 + imm;
    assign target   = (branch == br_jalr) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;
    assign nxtpc    = taken ? target : pc + XLEN'(4);

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            block,
    input  wire logic            valid_in,
    input  ex_ctrl_t             ctrl,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [XLEN-1:0] src1,
    input  wire logic [XLEN-1:0] src2,
    output logic                 stage_valid,
    output ex_res_t              res,
    output logic      [XLEN-1:0] alu_result,
    output logic      [XLEN-1:0] nxtpc
);

    ex_ctrl_t        ctrl_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] src1_q;
    logic [XLEN-1:0] src2_q;
    logic [XLEN-1:0] imm_x;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            zero;
    logic            lt;
    logic            ltu;
    logic            taken;

    always_ff @(posedge clk) begin
        if (!rst_n)
            stage_valid <= 1'b0;
        else if (!block)
            stage_valid <= valid_in;
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            ctrl_q <= ctrl;
            pc_q   <= pc;
            src1_q <= src1;
            src2_q <= src2;
        end
    end

    assign imm_x = XLEN'(signed'(ctrl_q.imm));  // sign extend to xlen

    assign op_a = ctrl_q.a_pc ? pc_q : src1_q;

    always_comb begin
        case (ctrl_q.b_src)
            b_four:  op_b = XLEN'(4);
            b_imm:   op_b = imm_x;
            default: op_b = src2_q;
        endcase
    end

    ex_alu #(.XLEN(XLEN)) alu0 (
        .op     (ctrl_q.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .zero   (zero),
        .lt     (lt),
        .ltu    (ltu)
    );

    ex_branch #(.XLEN(XLEN)) branch0 (
        .branch (ctrl_q.branch),
        .pc     (pc_q),
        .src1   (src1_q),
        .imm    (imm_x),
        .zero   (zero),
        .lt     (lt),
        .ltu    (ltu),
        .nxtpc  (nxtpc),
        .taken  (taken)
    );

    assign res = '{rd: ctrl_q.rd, reg_wr: ctrl_q.reg_wr, illegal: ctrl_q.illegal,
                   is_jmp_raw: taken};

endmodule

`default_nettype wire

// File: verilog/ex_result.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result import ex_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            block,
    input  wire logic            raise_intr,
    input  wire logic            stage_valid,
    input  ex_res_t              res,
    input  wire logic [XLEN-1:0] alu_result,
    input  wire logic [XLEN-1:0] nxtpc,
    output logic                 valid,
    output logic      [4:0]      rd,
    output logic                 reg_wr,
    output logic      [XLEN-1:0] result,
    output logic      [XLEN-1:0] nxtpc_out,
    output logic                 is_jmp,
    output logic                 error
);

    ex_res_t res_q;

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid <= 1'b0;
        else if (!block)
            valid <= stage_valid && !raise_intr;  // kill drops the slot
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            res_q     <= res;
            result    <= alu_result;
            nxtpc_out <= nxtpc;
        end
    end

    assign rd     = res_q.rd;
    assign reg_wr = valid && res_q.reg_wr;
    assign is_jmp = valid && res_q.is_jmp_raw;
    assign error  = valid && res_q.illegal;

endmodule

`default_nettype wire

// File: verilog/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top import ex_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            valid_in,
    input  wire logic [31:0]     instr,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [XLEN-1:0] src1,
    input  wire logic [XLEN-1:0] src2,
    input  wire logic            block,
    input  wire logic            raise_intr,
    output logic                 valid,
    output logic      [4:0]      rd,
    output logic                 reg_wr,
    output logic      [XLEN-1:0] result,
    output logic      [XLEN-1:0] nxtpc_out,
    output logic                 is_jmp,
    output logic                 error
);

    ex_ctrl_t        ctrl;
    ex_res_t         res;
    logic            stage_valid;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] nxtpc;

    ex_decode #(.XLEN(XLEN)) decode0 (
        .instr (instr),
        .ctrl  (ctrl)
    );

    ex_stage #(.XLEN(XLEN)) stage0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .block       (block),
        .valid_in    (valid_in),
        .ctrl        (ctrl),
        .pc          (pc),
        .src1        (src1),
        .src2        (src2),
        .stage_valid (stage_valid),
        .res         (res),
        .alu_result  (alu_result),
        .nxtpc       (nxtpc)
    );

    ex_result #(.XLEN(XLEN)) result0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .block       (block),
        .raise_intr  (raise_intr),
        .stage_valid (stage_valid),
        .res         (res),
        .alu_result  (alu_result),
        .nxtpc       (nxtpc),
        .valid       (valid),
        .rd          (rd),
        .reg_wr      (reg_wr),
        .result      (result),
        .nxtpc_out   (nxtpc_out),
        .is_jmp      (is_jmp),
        .error       (error)
    );

endmodule

`default_nettype wire

// File: sim/ex_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ex_properties #(
    parameter int XLEN = 64
) (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic            block,
    input wire logic            raise_intr,
    input wire logic            valid,
    input wire logic [4:0]      rd,
    input wire logic            reg_wr,
    input wire logic [XLEN-1:0] result,
    input wire logic [XLEN-1:0] nxtpc_out,
    input wire logic            is_jmp,
    input wire logic            error
);

    int failures = 0;

    reset_clears: assert property (@(posedge clk) !rst_n |=> !valid)
        else begin
            $error("valid high after a reset edge");
            failures++;
        end

    // a blocked edge freezes every output
    block_holds: assert property (@(posedge clk) rst_n && block |=>
        $stable(valid) && $stable(rd) && $stable(reg_wr) && $stable(result) &&
        $stable(nxtpc_out) && $stable(is_jmp) && $stable(error))
        else begin
            $error("outputs changed across a blocked edge");
            failures++;
        end

    kill_drops: assert property (@(posedge clk) rst_n && !block && raise_intr |=> !valid)
        else begin
            $error("valid high after a kill edge");
            failures++;
        end

    // a bad instruction never writes or redirects
    error_quiet: assert property (@(posedge clk) error |-> !reg_wr && !is_jmp)
        else begin
            $error("write or jump reported together with error");
            failures++;
        end

endmodule

bind ex_result ex_properties #(.XLEN(XLEN)) props0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .block      (block),
    .raise_intr (raise_intr),
    .valid      (valid),
    .rd         (rd),
    .reg_wr     (reg_wr),
    .result     (result),
    .nxtpc_out  (nxtpc_out),
    .is_jmp     (is_jmp),
    .error      (error)
);

`default_nettype wire

// File: sim/ex_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_tb import ex_pkg::*;;

    localparam int XLEN = 64;
    localparam int WAIT_LIMIT = 20;

    typedef struct packed {
        logic [63:0] result;
        logic [63:0] nxtpc;
        logic [4:0]  rd;
        logic        wr;
        logic        jmp;
        logic        err;
    } exp_t;

    logic            clk;
    logic            rst_n;
    logic            valid_in;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            block;
    logic            raise_intr;
    logic            valid;
    logic [4:0]      rd;
    logic            reg_wr;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] nxtpc_out;
    logic            is_jmp;
    logic            error;

    logic [31:0] lfsr_q;
    int          errors;
    int          tests_pass;
    int          tests_fail;

    ex_top #(.XLEN(XLEN)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .instr      (instr),
        .pc         (pc),
        .src1       (src1),
        .src2       (src2),
        .block      (block),
        .raise_intr (raise_intr),
        .valid      (valid),
        .rd         (rd),
        .reg_wr     (reg_wr),
        .result     (result),
        .nxtpc_out  (nxtpc_out),
        .is_jmp     (is_jmp),
        .error      (error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'hA300_0000 : lfsr_q >> 1;
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd_v);
        return {f7, 5'd2, 5'd1, f3, rd_v, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] im, input logic [2:0] f3,
                                          input logic [4:0] rd_v, input logic [6:0] op);
        return {im, 5'd1, f3, rd_v, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] im, input logic [4:0] rd_v,
                                          input logic [6:0] op);
        return {im, rd_v, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] im, input logic [2:0] f3);
        return {im[12], im[10:5], 5'd2, 5'd1, f3, im[4:1], im[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] im, input logic [4:0] rd_v);
        return {im[20], im[10:1], im[11], im[19:12], rd_v, 7'b1101111};
    endfunction

    // funct3 table shared by register and immediate forms
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic [63:0] x,
                                            input logic [63:0] y);
        case (f3)
            3'b000:  return x + y;
            3'b001:  return x << y[5:0];
            3'b010:  return {63'b0, $signed(x) < $signed(y)};
            3'b011:  return {63'b0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return x >> y[5:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic exp_t model(input logic [31:0] ins, input logic [63:0] p,
                                   input logic [63:0] a, input logic [63:0] b);
        exp_t        e;
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic [63:0] imm_b;
        logic [63:0] imm_j;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        tk;
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
        imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e       = '0;
        e.rd    = ins[11:7];
        e.nxtpc = p + 64'd4;
        tk      = 1'b0;
        case (ins[6:0])
            op_reg: begin
                e.wr = 1'b1;
                if (f7 == 7'h20 && f3 == 3'b000)
                    e.result = a - b;
                else if (f7 == 7'h20 && f3 == 3'b101)
                    e.result = $signed(a) >>> b[5:0];
                else if (f7 != 7'h00)
                    e.err = 1'b1;
                else
                    e.result = alu_ref(f3, a, b);
            end
            op_imm: begin
                e.wr = 1'b1;
                if (f3 == 3'b001) begin
                    e.err    = ins[31:26] != 6'b0;
                    e.result = a << ins[25:20];
                end else if (f3 == 3'b101) begin
                    if (ins[31:26] == 6'b010000)
                        e.result = $signed(a) >>> ins[25:20];
                    else if (ins[31:26] == 6'b0)
                        e.result = a >> ins[25:20];
                    else
                        e.err = 1'b1;
                end else begin
                    e.result = alu_ref(f3, a, imm_i);
                end
            end
            op_lui: begin
                e.wr     = 1'b1;
                e.result = imm_u;
            end
            op_auipc: begin
                e.wr     = 1'b1;
                e.result = p + imm_u;
            end
            op_jal: begin
                e.wr     = 1'b1;
                e.result = p + 64'd4;
                e.jmp    = 1'b1;
                e.nxtpc  = p + imm_j;
            end
            op_jalr: begin
                if (f3 != 3'b000) begin
                    e.err = 1'b1;
                end else begin
                    e.wr     = 1'b1;
                    e.result = p + 64'd4;
                    e.jmp    = 1'b1;
                    e.nxtpc  = (a + imm_i) & ~64'd1;
                end
            end
            op_branch: begin
                case (f3)
                    3'b000:  tk = a == b;
                    3'b001:  tk = a != b;
                    3'b100:  tk = $signed(a) < $signed(b);
                    3'b101:  tk = $signed(a) >= $signed(b);
                    3'b110:  tk = a < b;
                    3'b111:  tk = a >= b;
                    default: e.err = 1'b1;
                endcase
                e.jmp = tk;
                if (tk)
                    e.nxtpc = p + imm_b;
            end
            default: e.err = 1'b1;
        endcase
        if (e.err) begin
            e.wr  = 1'b0;
            e.jmp = 1'b0;
        end
        return e;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_out(input string name, input exp_t e);
        check({name, " valid"}, 64'd1, valid);
        check({name, " rd"}, e.rd, rd);
        check({name, " reg_wr"}, e.wr, reg_wr);
        check({name, " is_jmp"}, e.jmp, is_jmp);
        check({name, " error"}, e.err, error);
        if (e.wr)
            check({name, " result"}, e.result, result);
        if (!e.err)
            check({name, " nxtpc"}, e.nxtpc, nxtpc_out);
    endtask

    task automatic present(input logic [31:0] ins, input logic [63:0] p,
                           input logic [63:0] a, input logic [63:0] b);
        @(posedge clk);
        valid_in <= 1'b1;
        instr    <= ins;
        pc       <= p;
        src1     <= a;
        src2     <= b;
    endtask

    // n counts falling edges until valid shows up
    task automatic wait_valid(input string name, output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (valid !== 1'b1 && n < WAIT_LIMIT);
        if (valid !== 1'b1) begin
            $display("%s: no valid output within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic exec_one(input string name, input logic [31:0] ins, input logic [63:0] p,
                            input logic [63:0] a, input logic [63:0] b);
        exp_t e;
        int   n;
        e = model(ins, p, a, b);
        present(ins, p, a, b);
        @(posedge clk);             // capture edge
        valid_in <= 1'b0;
        wait_valid(name, n);
        if (valid === 1'b1) begin
            check({name, " latency"}, 64'd2, n);
            compare_out(name, e);
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            tests_pass++;
            $display("test %s: passed", name);
        end else begin
            tests_fail++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_rtype;
        int         err0;
        logic [2:0] f3;
        logic [6:0] f7;
        err0 = errors;
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : (k == 8) ? 3'b000 : 3'b101;   // sub and sra last
            f7 = (k < 8) ? 7'h00 : 7'h20;
            for (int j = 0; j < 3; j++)
                exec_one("rtype", enc_r(f7, f3, 5'(k + 1)), 64'h1000, rand_bits(64),
                         rand_bits(64));
        end
        finish_test("rtype alu", err0);
    endtask

    task automatic test_imm;
        int          err0;
        logic [11:0] im;
        logic [5:0]  sh;
        logic [19:0] up;
        err0 = errors;
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) begin
                for (int j = 0; j < 3; j++) begin
                    im = (j == 0) ? 12'hffb : (j == 1) ? 12'h7f0 : 12'(rand_bits(12));
                    exec_one("imm alu", enc_i(im, 3'(f), 5'd6, op_imm), 64'h2000,
                             rand_bits(64), 64'h0);
                end
            end
        end
        for (int j = 0; j < 3; j++) begin
            sh = 6'(rand_bits(6));
            exec_one("slli", enc_i({6'b000000, sh}, 3'b001, 5'd7, op_imm), 64'h2000,
                     rand_bits(64), 64'h0);
            exec_one("srli", enc_i({6'b000000, sh}, 3'b101, 5'd7, op_imm), 64'h2000,
                     rand_bits(64), 64'h0);
            exec_one("srai", enc_i({6'b010000, sh}, 3'b101, 5'd8, op_imm), 64'h2000,
                     rand_bits(64) | 64'h8000_0000_0000_0000, 64'h0);
            up = {j[0], 19'(rand_bits(19))};    // both signs of the upper immediate
            exec_one("lui", enc_u(up, 5'd9, op_lui), 64'h2000, 64'h0, 64'h0);
            exec_one("auipc", enc_u(up, 5'd10, op_auipc), 64'(rand_bits(30)) << 2,
                     64'h0, 64'h0);
        end
        finish_test("immediate and upper", err0);
    endtask

    task automatic test_branch;
        int          err0;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] p;
        logic [12:0] im;
        err0 = errors;
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                x  = rand_bits(64) & 64'h7fff_ffff_ffff_ffff;
                y  = rand_bits(64) | 64'h8000_0000_0000_0000;  // signed and unsigned disagree
                im = {12'(rand_bits(12)), 1'b0};
                p  = 64'(rand_bits(30)) << 2;
                exec_one("branch equal", enc_b(im, 3'(f)), p, x, x);
                exec_one("branch xy", enc_b(im, 3'(f)), p, x, y);
                exec_one("branch yx", enc_b(im, 3'(f)), p, y, x);
            end
        end
        finish_test("conditional branch", err0);
    endtask

    task automatic test_jump;
        int err0;
        err0 = errors;
        for (int j = 0; j < 4; j++) begin
            exec_one("jal", enc_j({20'(rand_bits(20)), 1'b0}, 5'(j + 1)),
                     64'(rand_bits(30)) << 2, 64'h0, 64'h0);
            exec_one("jalr", enc_i(12'(rand_bits(12)), 3'b000, 5'(j + 1), op_jalr),
                     64'(rand_bits(30)) << 2, rand_bits(64), 64'h0);
        end
        finish_test("jump", err0);
    endtask

    task automatic test_pipe_stall;
        int          err0;
        int          n;
        logic [31:0] ia;
        logic [31:0] ib;
        logic [31:0] ic;
        logic [63:0] a0;
        logic [63:0] a1;
        exp_t        ea;
        exp_t        eb;
        err0 = errors;
        a0 = rand_bits(64);
        a1 = rand_bits(64);
        ia = enc_r(7'h00, 3'b000, 5'd3);
        ib = enc_r(7'h20, 3'b000, 5'd4);
        ic = enc_i(12'h123, 3'b000, 5'd5, op_imm);
        ea = model(ia, 64'h3000, a0, a1);
        eb = model(ib, 64'h3004, a1, a0);
        // back to back
        present(ia, 64'h3000, a0, a1);
        present(ib, 64'h3004, a1, a0);
        @(posedge clk);
        valid_in <= 1'b0;
        wait_valid("pipe a", n);
        check("pipe a latency", 64'd1, n);  // a was captured one edge earlier
        compare_out("pipe a", ea);
        @(negedge clk);
        compare_out("pipe b", eb);
        @(negedge clk);
        check("pipe drain valid", 64'd0, valid);
        // stall while a sits in result, b in stage and c on the inputs
        present(ia, 64'h3000, a0, a1);
        present(ib, 64'h3004, a1, a0);
        present(ic, 64'h3008, a0, a1);
        block <= 1'b1;
        wait_valid("stall a", n);
        compare_out("stall a", ea);
        repeat (3) begin
            @(negedge clk);
            compare_out("stall hold", ea);
        end
        @(posedge clk);
        block    <= 1'b0;
        valid_in <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare_out("stall release b", eb);
        @(negedge clk);
        check("stall input ignored", 64'd0, valid);
        finish_test("pipeline and stall", err0);
    endtask

    task automatic test_kill_illegal;
        int          err0;
        int          n;
        logic [31:0] ia;
        logic [31:0] ib;
        exp_t        eb;
        err0 = errors;
        ia = enc_r(7'h00, 3'b100, 5'd13);
        ib = enc_i(12'h0ff, 3'b111, 5'd14, op_imm);
        eb = model(ib, 64'h4004, 64'h1234_5678_9abc_def0, 64'h0);
        present(ia, 64'h4000, rand_bits(64), rand_bits(64));
        present(ib, 64'h4004, 64'h1234_5678_9abc_def0, 64'h0);
        raise_intr <= 1'b1;         // a sits in the stage at the next edge
        @(posedge clk);
        raise_intr <= 1'b0;
        valid_in   <= 1'b0;
        @(negedge clk);
        check("kill a valid", 64'd0, valid);
        wait_valid("kill b", n);
        if (valid === 1'b1)
            compare_out("kill b", eb);
        exec_one("illegal load", enc_i(12'h010, 3'b011, 5'd11, 7'b0000011), 64'h4100,
                 rand_bits(64), 64'h0);
        exec_one("illegal mul", enc_r(7'h01, 3'b000, 5'd12), 64'h4104, rand_bits(64),
                 rand_bits(64));
        exec_one("illegal branch", enc_b(13'h010, 3'b010), 64'h4108, 64'h5, 64'h5);
        finish_test("kill and illegal", err0);
    endtask

    initial begin
        rst_n      = 1'b0;
        valid_in   = 1'b0;
        instr      = '0;
        pc         = '0;
        src1       = '0;
        src2       = '0;
        block      = 1'b0;
        raise_intr = 1'b0;
        lfsr_q     = 32'd19759;
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_rtype;
        test_imm;
        test_branch;
        test_jump;
        test_pipe_stall;
        test_kill_illegal;
        $display("tests passed %0d, failed %0d, assertion failures %0d", tests_pass,
                 tests_fail, dut0.result0.props0.failures);
        if (tests_fail == 0 && errors == 0 && dut0.result0.props0.failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #100000;
        $display("simulation did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_stage.sv
verilog/ex_result.sv
verilog/ex_top.sv
sim/ex_properties.sv
sim/ex_tb.sv

// File: Bender.yml
package:
  name: ex_subsystem

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_decode.sv
  - verilog/ex_alu.sv
  - verilog/ex_branch.sv
  - verilog/ex_stage.sv
  - verilog/ex_result.sv
  - verilog/ex_top.sv
  - target: simulation
    files:
      - sim/ex_properties.sv
      - sim/ex_tb.sv
